/* dma_backend.f */
+incdir+.
dma_backend_pkg.sv
dma_req_queue.sv
dma_burst_splitter.sv
dma_data_mover.sv
dma_backend.sv
dma_backend_chk.sv
tb_clk_gen.sv
tb_dma_backend.sv

/* dma_backend.sv */
// top level of the word dma backend, connects queue, src and dst splitters and data mover
`timescale 1ns/1ps
`default_nettype none

module dma_backend import dma_backend_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // copy requests
  input  dma_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  // read bursts and data
  output mem_burst_t rd_req_o,
  output logic       rd_req_valid_o,
  input  logic       rd_req_ready_i,
  input  word_t      rd_data_i,
  input  logic       rd_valid_i,
  output logic       rd_ready_o,
  // write bursts, data and responses
  output mem_burst_t wr_req_o,
  output logic       wr_req_valid_o,
  input  logic       wr_req_ready_i,
  output word_t      wr_data_o,
  output logic       wr_last_o,
  output logic       wr_valid_o,
  input  logic       wr_ready_i,
  input  logic       wr_resp_valid_i,
  output logic       wr_resp_ready_o,
  // status
  output logic       idle_o,
  output logic       trans_complete_o
);

  dma_req_t  cur_req;
  logic      start, src_done, dst_done, q_busy, mover_empty;
  wr_burst_t src_burst, dst_burst;
  logic      dst_burst_valid, dst_burst_ready;

  // ----------------------------------------
  // request queue
  // ----------------------------------------
  dma_req_queue i_req_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .cur_req_o       (cur_req),
    .start_o         (start),
    .src_done_i      (src_done),
    .dst_done_i      (dst_done),
    .trans_complete_i(trans_complete_o),
    .busy_o          (q_busy)
  );

  // ----------------------------------------
  // splitters, read side drives the bus
  // ----------------------------------------
  dma_burst_splitter i_src_splitter (
    .clk_i(clk_i), .rst_ni(rst_ni), .start_i(start),
    .base_i(cur_req.src), .num_words_i(cur_req.num_words), .deburst_i(cur_req.deburst),
    .burst_o(src_burst), .burst_valid_o(rd_req_valid_o), .burst_ready_i(rd_req_ready_i),
    .done_o(src_done)
  );

  // read bursts carry no end marker
  assign rd_req_o = src_burst.burst;

  dma_burst_splitter i_dst_splitter (
    .clk_i(clk_i), .rst_ni(rst_ni), .start_i(start),
    .base_i(cur_req.dst), .num_words_i(cur_req.num_words), .deburst_i(cur_req.deburst),
    .burst_o(dst_burst), .burst_valid_o(dst_burst_valid), .burst_ready_i(dst_burst_ready),
    .done_o(dst_done)
  );

  // ----------------------------------------
  // data mover
  // ----------------------------------------
  dma_data_mover i_data_mover (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .rd_data_i(rd_data_i), .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o),
    .wr_burst_i(dst_burst), .wr_burst_valid_i(dst_burst_valid),
    .wr_burst_ready_o(dst_burst_ready),
    .wr_req_o(wr_req_o), .wr_req_valid_o(wr_req_valid_o), .wr_req_ready_i(wr_req_ready_i),
    .wr_data_o(wr_data_o), .wr_last_o(wr_last_o), .wr_valid_o(wr_valid_o),
    .wr_ready_i(wr_ready_i),
    .wr_resp_valid_i(wr_resp_valid_i), .wr_resp_ready_o(wr_resp_ready_o),
    .trans_complete_o(trans_complete_o), .empty_o(mover_empty)
  );

  // nothing queued, splitting or buffered
  assign idle_o = !q_busy && src_done && dst_done && mover_empty;

endmodule

`default_nettype wire

/* dma_backend_cfg.svh */
// widths, page geometry and buffer depths of the dma backend, included by the package and rtl
`ifndef DMA_BACKEND_CFG_SVH
`define DMA_BACKEND_CFG_SVH

// word address and data word
`define DMA_ADDR_W 16
`define DMA_DATA_W 32

// request length in words, burst length in beats
`define DMA_LEN_W 12
`define DMA_BLEN_W 5

// page size in words, must be a power of two
`define DMA_PAGE_WORDS 64
// upper bound on beats per burst
`define DMA_MAX_BEATS 16

// buffer depths, all powers of two
`define DMA_REQ_DEPTH 4
`define DMA_DATA_DEPTH 8
// write bursts that may await a response
`define DMA_OUTST_DEPTH 8

`endif

/* dma_backend_chk.sv */
// bus protocol assertions of the dma backend, bound into the top level by the testbench build
`timescale 1ns/1ps
`default_nettype none

module dma_backend_chk import dma_backend_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input mem_burst_t rd_req_o,
  input logic       rd_req_valid_o,
  input logic       rd_req_ready_i,
  input mem_burst_t wr_req_o,
  input logic       wr_req_valid_o,
  input logic       wr_req_ready_i,
  input word_t      wr_data_o,
  input logic       wr_last_o,
  input logic       wr_valid_o,
  input logic       wr_ready_i,
  input logic       idle_o,
  input logic       trans_complete_o
);

  // failed assertions, read by the testbench at the end
  int fails = 0;
  // write beats owed on issued bursts, counted from the bus side
  int beats_owed;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_owed <= 0;
    end else begin
      beats_owed <= beats_owed +
                    ((wr_req_valid_o && wr_req_ready_i) ? int'(wr_req_o.len) : 0) -
                    ((wr_valid_o && wr_ready_i) ? 1 : 0);
    end
  end

  // ----------------------------------------
  // stalled valids hold their payload
  // ----------------------------------------
  rd_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_valid_o && !rd_req_ready_i |=> rd_req_valid_o && $stable(rd_req_o))
    else begin
      fails++;
      $error("read burst dropped or changed while stalled");
    end

  wr_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req_valid_o && !wr_req_ready_i |=> wr_req_valid_o && $stable(wr_req_o))
    else begin
      fails++;
      $error("write burst dropped or changed while stalled");
    end

  // data and last move together
  wr_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable({wr_data_o, wr_last_o}))
    else begin
      fails++;
      $error("write beat dropped or changed while stalled");
    end

  // ----------------------------------------
  // status rules
  // ----------------------------------------
  cmpl_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_complete_o |=> !trans_complete_o)
    else begin
      fails++;
      $error("completion high for two cycles in a row");
    end

  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_o |-> !wr_valid_o && beats_owed == 0)
    else begin
      fails++;
      $error("write beat offered or owed while the backend reports idle");
    end

endmodule

bind dma_backend dma_backend_chk i_dma_backend_chk (.*);

`default_nettype wire

/* dma_backend_pkg.sv */
// request, burst and state types of the dma backend, imported by the rtl and the testbench
`default_nettype none

`include "dma_backend_cfg.svh"

package dma_backend_pkg;

  // ----------------------------------------
  // scalar types
  // ----------------------------------------
  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] word_t;
  // request length in words
  typedef logic [`DMA_LEN_W-1:0] len_t;
  // burst length in beats, 1 up to max beats
  typedef logic [`DMA_BLEN_W-1:0] blen_t;

  // ----------------------------------------
  // transfer descriptors
  // ----------------------------------------
  // one copy request, 46 bits
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_words;
    logic  deburst;
    logic  serialize;
  } dma_req_t;

  // one bus burst
  typedef struct packed {
    addr_t addr;
    blen_t len;
  } mem_burst_t;

  // bus burst plus end-of-request marker
  typedef struct packed {
    mem_burst_t burst;
    logic       last;
  } wr_burst_t;

  // splitter fsm
  typedef enum logic {SPLIT_IDLE, SPLIT_ISSUE} split_state_e;

endpackage

`default_nettype wire

/* dma_burst_splitter.sv */
// cuts one word range into page-safe bursts and offers them one per cycle, used for src and dst
`timescale 1ns/1ps
`default_nettype none

`include "dma_backend_cfg.svh"

module dma_burst_splitter import dma_backend_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  addr_t     base_i,
  input  len_t      num_words_i,
  input  logic      deburst_i,
  output wr_burst_t burst_o,
  output logic      burst_valid_o,
  input  logic      burst_ready_i,
  output logic      done_o
);

  localparam int unsigned page_bits = $clog2(`DMA_PAGE_WORDS);

  split_state_e         state_q, state_d;
  addr_t                addr_q;
  len_t                 rem_q;
  logic                 deburst_q;
  logic [page_bits-1:0] page_off;
  len_t                 to_page;
  len_t                 blen;
  logic                 is_last;
  logic                 fire;

  // ----------------------------------------
  // burst length
  // ----------------------------------------
  // words left before the next page boundary
  assign page_off = addr_q[page_bits-1:0];
  assign to_page  = len_t'(`DMA_PAGE_WORDS) - len_t'(page_off);

  // smallest of remaining, to page and max beats
  always_comb begin
    blen = rem_q;
    if (to_page < blen) blen = to_page;
    if (len_t'(`DMA_MAX_BEATS) < blen) blen = len_t'(`DMA_MAX_BEATS);
    // single beats only
    if (deburst_q) blen = len_t'(1);
  end

  assign is_last = rem_q == blen;
  assign fire    = burst_valid_o && burst_ready_i;

  assign burst_o.burst.addr = addr_q;
  assign burst_o.burst.len  = blen_t'(blen);
  assign burst_o.last       = is_last;
  assign burst_valid_o      = state_q == SPLIT_ISSUE;
  assign done_o             = state_q == SPLIT_IDLE;

  // ----------------------------------------
  // fsm
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SPLIT_IDLE:  if (start_i) state_d = SPLIT_ISSUE;
      SPLIT_ISSUE: if (fire && is_last) state_d = SPLIT_IDLE;
      default:     state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // cursor, loaded on start and advanced per accepted burst
  always_ff @(posedge clk_i) begin
    if (state_q == SPLIT_IDLE && start_i) begin
      addr_q    <= base_i;
      rem_q     <= num_words_i;
      deburst_q <= deburst_i;
    end else if (fire) begin
      addr_q <= addr_q + addr_t'(blen);
      rem_q  <= rem_q - blen;
    end
  end

endmodule

`default_nettype wire

/* dma_data_mover.sv */
// moves read words to the write channel, frames write beats and retires requests on responses
`timescale 1ns/1ps
`default_nettype none

`include "dma_backend_cfg.svh"

module dma_data_mover import dma_backend_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  word_t      rd_data_i,
  input  logic       rd_valid_i,
  output logic       rd_ready_o,
  input  wr_burst_t  wr_burst_i,
  input  logic       wr_burst_valid_i,
  output logic       wr_burst_ready_o,
  output mem_burst_t wr_req_o,
  output logic       wr_req_valid_o,
  input  logic       wr_req_ready_i,
  output word_t      wr_data_o,
  output logic       wr_last_o,
  output logic       wr_valid_o,
  input  logic       wr_ready_i,
  input  logic       wr_resp_valid_i,
  output logic       wr_resp_ready_o,
  output logic       trans_complete_o,
  output logic       empty_o
);

  localparam int unsigned dptr_w = $clog2(`DMA_DATA_DEPTH);
  localparam int unsigned dcnt_w = $clog2(`DMA_DATA_DEPTH + 1);
  localparam int unsigned optr_w = $clog2(`DMA_OUTST_DEPTH);
  localparam int unsigned ocnt_w = $clog2(`DMA_OUTST_DEPTH + 1);

  word_t             data_mem [`DMA_DATA_DEPTH];
  blen_t             beat_mem [`DMA_OUTST_DEPTH];
  logic              outst_mem [`DMA_OUTST_DEPTH];
  logic [dptr_w-1:0] data_wptr_q, data_rptr_q;
  logic [dcnt_w-1:0] data_cnt_q;
  logic [optr_w-1:0] beat_wptr_q, beat_rptr_q, outst_wptr_q, outst_rptr_q;
  logic [ocnt_w-1:0] beat_cnt_q, outst_cnt_q;
  blen_t             sent_q;
  logic              complete_q;
  logic              rd_push, aw_fire, w_fire, w_done, resp_pop;

  // ----------------------------------------
  // data fifo, read side in, write side out
  // ----------------------------------------
  assign rd_ready_o = data_cnt_q != dcnt_w'(`DMA_DATA_DEPTH);
  assign rd_push    = rd_valid_i && rd_ready_o;
  assign wr_data_o  = data_mem[data_rptr_q];

  // ----------------------------------------
  // write burst issue
  // ----------------------------------------
  // beat entries retire before their outstanding entry,
  // so outstanding room covers both fifos
  assign wr_req_o         = wr_burst_i.burst;
  assign wr_req_valid_o   = wr_burst_valid_i && outst_cnt_q != ocnt_w'(`DMA_OUTST_DEPTH);
  assign wr_burst_ready_o = wr_req_ready_i && outst_cnt_q != ocnt_w'(`DMA_OUTST_DEPTH);
  assign aw_fire          = wr_req_valid_o && wr_req_ready_i;

  // ----------------------------------------
  // write beats
  // ----------------------------------------
  // beat needs both an issued burst and a buffered word
  assign wr_valid_o = beat_cnt_q != '0 && data_cnt_q != '0;
  assign wr_last_o  = (sent_q + 1'b1) == beat_mem[beat_rptr_q];
  assign w_fire     = wr_valid_o && wr_ready_i;
  assign w_done     = w_fire && wr_last_o;

  // responses in burst order, never stalled
  assign wr_resp_ready_o  = 1'b1;
  assign resp_pop         = wr_resp_valid_i && outst_cnt_q != '0;
  assign trans_complete_o = complete_q;
  assign empty_o = data_cnt_q == '0 && beat_cnt_q == '0 && outst_cnt_q == '0;

  always_ff @(posedge clk_i) begin
    if (rd_push) data_mem[data_wptr_q] <= rd_data_i;
    if (aw_fire) begin
      beat_mem[beat_wptr_q]   <= wr_burst_i.burst.len;
      outst_mem[outst_wptr_q] <= wr_burst_i.last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_wptr_q  <= '0;
      data_rptr_q  <= '0;
      data_cnt_q   <= '0;
      beat_wptr_q  <= '0;
      beat_rptr_q  <= '0;
      beat_cnt_q   <= '0;
      outst_wptr_q <= '0;
      outst_rptr_q <= '0;
      outst_cnt_q  <= '0;
      sent_q       <= '0;
      complete_q   <= 1'b0;
    end else begin
      if (rd_push) data_wptr_q <= data_wptr_q + 1'b1;
      if (w_fire) data_rptr_q <= data_rptr_q + 1'b1;
      data_cnt_q <= data_cnt_q + dcnt_w'(rd_push) - dcnt_w'(w_fire);
      // beat counter restarts at each burst end
      if (w_done) sent_q <= '0;
      else if (w_fire) sent_q <= sent_q + 1'b1;
      if (aw_fire) beat_wptr_q <= beat_wptr_q + 1'b1;
      if (w_done) beat_rptr_q <= beat_rptr_q + 1'b1;
      beat_cnt_q <= beat_cnt_q + ocnt_w'(aw_fire) - ocnt_w'(w_done);
      if (aw_fire) outst_wptr_q <= outst_wptr_q + 1'b1;
      if (resp_pop) outst_rptr_q <= outst_rptr_q + 1'b1;
      outst_cnt_q <= outst_cnt_q + ocnt_w'(aw_fire) - ocnt_w'(resp_pop);
      // one cycle event for the final burst of a request
      complete_q <= resp_pop && outst_mem[outst_rptr_q];
    end
  end

endmodule

`default_nettype wire

/* dma_req_queue.sv */
// request fifo of the dma backend, drops empty requests and gates each start on the splitters
`timescale 1ns/1ps
`default_nettype none

`include "dma_backend_cfg.svh"

module dma_req_queue import dma_backend_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  dma_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output dma_req_t cur_req_o,
  output logic     start_o,
  input  logic     src_done_i,
  input  logic     dst_done_i,
  input  logic     trans_complete_i,
  output logic     busy_o
);

  localparam int unsigned ptr_w = $clog2(`DMA_REQ_DEPTH);
  localparam int unsigned cnt_w = $clog2(`DMA_REQ_DEPTH + 1);
  // at most one request per outstanding burst, plus the one being split
  localparam int unsigned fl_w = $clog2(`DMA_OUTST_DEPTH + 2);

  dma_req_t         fifo_mem [`DMA_REQ_DEPTH];
  logic [ptr_w-1:0] wptr_q, rptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic [fl_w-1:0]  inflight_q;
  logic             push, pop, empty, discard, gate_open;

  // ----------------------------------------
  // storage
  // ----------------------------------------
  assign empty       = cnt_q == '0;
  assign req_ready_o = cnt_q != cnt_w'(`DMA_REQ_DEPTH);
  assign push        = req_valid_i && req_ready_o;
  assign cur_req_o   = fifo_mem[rptr_q];

  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wptr_q] <= req_i;
  end

  // ----------------------------------------
  // dispatch
  // ----------------------------------------
  // serialized head waits until nothing else is in flight,
  // a retiring last request counts as gone already
  assign gate_open = !cur_req_o.serialize || inflight_q == '0 ||
                     (inflight_q == fl_w'(1) && trans_complete_i);
  // zero length head leaves without touching the splitters
  assign discard = !empty && cur_req_o.num_words == '0;
  assign start_o = !empty && !discard && src_done_i && dst_done_i && gate_open;
  assign pop     = start_o || discard;
  assign busy_o  = !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      cnt_q      <= '0;
      inflight_q <= '0;
    end else begin
      if (push) wptr_q <= wptr_q + 1'b1;
      if (pop) rptr_q <= rptr_q + 1'b1;
      cnt_q <= cnt_q + cnt_w'(push) - cnt_w'(pop);
      // started but not yet retired requests
      if (start_o && !trans_complete_i) begin
        inflight_q <= inflight_q + 1'b1;
      end else if (!start_o && trans_complete_i) begin
        inflight_q <= inflight_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock and reset source, 8 ns period with reset held low for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release just after the 8th rising edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_dma_backend.sv */
// random copy testbench of the dma backend, memory bus model against a reference copy
`timescale 1ns/1ps
`default_nettype none

`include "dma_backend_cfg.svh"

module tb_dma_backend import dma_backend_pkg::*; ();

  localparam int unsigned num_reqs = 24;

  // expected burst, tagged with the ordinal of its nonzero request
  typedef struct packed {
    int    ord;
    logic  first;
    logic  deb;
    addr_t addr;
    blen_t len;
  } exp_burst_t;

  logic       clk_i, rst_ni;
  dma_req_t   req_i;
  logic       req_valid_i, req_ready_o;
  mem_burst_t rd_req_o, wr_req_o;
  logic       rd_req_valid_o, rd_req_ready_i, rd_valid_i, rd_ready_o;
  word_t      rd_data_i, wr_data_o;
  logic       wr_req_valid_o, wr_req_ready_i, wr_last_o, wr_valid_o, wr_ready_i;
  logic       wr_resp_valid_i, wr_resp_ready_o, idle_o, trans_complete_o;

  integer     seed;
  word_t      mem [2**`DMA_ADDR_W];
  word_t      ref_mem [2**`DMA_ADDR_W];
  dma_req_t   reqs [num_reqs];
  // idle cycles after each request
  int         gap [num_reqs];
  exp_burst_t exp_rd[$], exp_wr[$];
  mem_burst_t rd_pend[$], wr_pend[$];
  // write bursts through each nonzero request, serialize flag per request
  int         cum_wr [num_reqs];
  logic       ser_of [num_reqs];
  int         n_nonzero = 0, limit = 2000, cycles = 0;
  int         rd_beat = 0, wr_beat = 0, resp_owed = 0, resp_cnt = 0, cmpl_cnt = 0;
  int         err_reset = 0, err_data = 0, err_shape = 0, err_cmpl = 0, err_ser = 0;
  int         err_idle = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  dma_backend i_dma_backend (.*);

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // cut a range by the page, max beats and deburst rules
  task automatic expect_bursts(input addr_t base, input int len, input logic deb,
                               input int ord, input bit to_rd);
    addr_t      a;
    int         rem;
    int         n;
    exp_burst_t e;
    a = base;
    rem = len;
    while (rem > 0) begin
      n = rem;
      if (`DMA_PAGE_WORDS - (a % `DMA_PAGE_WORDS) < n) n = `DMA_PAGE_WORDS - (a % `DMA_PAGE_WORDS);
      if (n > `DMA_MAX_BEATS) n = `DMA_MAX_BEATS;
      if (deb) n = 1;
      e.ord = ord;
      e.first = rem == len;
      e.deb = deb;
      e.addr = a;
      e.len = blen_t'(n);
      if (to_rd) exp_rd.push_back(e);
      else exp_wr.push_back(e);
      a = a + addr_t'(n);
      rem -= n;
    end
  endtask

  task automatic check_burst(input string name, input mem_burst_t got, input exp_burst_t e);
    assert (got.addr == e.addr) else begin
      $display("Error at %0t: %s.addr = %h, expected %h", $time, name, got.addr, e.addr);
      err_shape++;
    end
    assert (got.len == e.len) else begin
      $display("Error at %0t: %s.len = %0d, expected %0d", $time, name, got.len, e.len);
      err_shape++;
    end
    assert (got.len >= 1 && got.len <= `DMA_MAX_BEATS && (!e.deb || got.len == 1) &&
            (got.addr % `DMA_PAGE_WORDS) + got.len <= `DMA_PAGE_WORDS) else begin
      $display("%s at %0t breaks the length, page or deburst rule", name, $time);
      err_shape++;
    end
  endtask

  // ----------------------------------------
  // memory bus model and monitors
  // ----------------------------------------
  always @(posedge clk_i) begin
    mem_burst_t b;
    exp_burst_t e;
    logic       rd_hold;
    rd_hold = rd_valid_i && !rd_ready_o;
    if (rst_ni) begin
      // completion checked before this edge's response is counted
      if (trans_complete_o) begin
        assert (cmpl_cnt < n_nonzero) else begin
          $display("completion pulse at %0t after every request had retired", $time);
          err_cmpl++;
        end
        if (cmpl_cnt < n_nonzero) begin
          assert (resp_cnt == cum_wr[cmpl_cnt]) else begin
            $display("Error at %0t: trans_complete_o %0d after %0d write responses, expected %0d",
                     $time, cmpl_cnt, resp_cnt, cum_wr[cmpl_cnt]);
            err_cmpl++;
          end
        end
        cmpl_cnt++;
      end
      if (wr_resp_valid_i) begin
        assert (wr_resp_ready_o) else begin
          $display("Error at %0t: wr_resp_ready_o = %b, expected 1", $time, wr_resp_ready_o);
          err_cmpl++;
        end
        resp_cnt++;
        resp_owed--;
      end
      if (rd_req_valid_o && rd_req_ready_i) begin
        assert (exp_rd.size() != 0) else begin
          $display("read burst at %0t that no request asked for", $time);
          err_shape++;
        end
        if (exp_rd.size() != 0) begin
          e = exp_rd.pop_front();
          check_burst("rd_req_o", rd_req_o, e);
          // serialized request reads only after all earlier ones retired
          assert (!(e.first && ser_of[e.ord]) || cmpl_cnt == e.ord) else begin
            $display("Error at %0t: completions before rd_req_o %h = %0d, expected %0d",
                     $time, rd_req_o.addr, cmpl_cnt, e.ord);
            err_ser++;
          end
        end
        rd_pend.push_back(rd_req_o);
      end
      if (wr_req_valid_o && wr_req_ready_i) begin
        assert (exp_wr.size() != 0) else begin
          $display("write burst at %0t that no request asked for", $time);
          err_shape++;
        end
        if (exp_wr.size() != 0) begin
          e = exp_wr.pop_front();
          check_burst("wr_req_o", wr_req_o, e);
        end
        wr_pend.push_back(wr_req_o);
      end
      if (rd_valid_i && rd_ready_o) begin
        rd_beat++;
        if (rd_beat == rd_pend[0].len) begin
          void'(rd_pend.pop_front());
          rd_beat = 0;
        end
      end
      if (wr_valid_o && wr_ready_i) begin
        assert (wr_pend.size() != 0) else begin
          $display("write beat at %0t without an issued write burst", $time);
          err_shape++;
        end
        if (wr_pend.size() != 0) begin
          b = wr_pend[0];
          assert (wr_last_o == (wr_beat + 1 == b.len)) else begin
            $display("Error at %0t: wr_last_o = %b, expected %b", $time, wr_last_o,
                     wr_beat + 1 == b.len);
            err_shape++;
          end
          mem[addr_t'(b.addr + wr_beat)] = wr_data_o;
          wr_beat++;
          // burst done, one response owed
          if (wr_beat == b.len) begin
            void'(wr_pend.pop_front());
            wr_beat = 0;
            resp_owed++;
          end
        end
      end
    end
    // next cycle's bus inputs, random stalls
    #1;
    rd_req_ready_i = ($random(seed) & 3) != 0;
    wr_req_ready_i = ($random(seed) & 3) != 0;
    wr_ready_i = ($random(seed) & 3) != 0;
    wr_resp_valid_i = resp_owed > 0 && ($random(seed) & 1);
    if (!rd_hold) begin
      rd_valid_i = rd_pend.size() != 0 && ($random(seed) & 3) != 0;
      if (rd_valid_i) rd_data_i = mem[addr_t'(rd_pend[0].addr + rd_beat)];
    end
  end

  // run limit from the total request length
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("run stopped after %0d cycles, requests did not retire in time", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus and run control
  // ----------------------------------------
  initial begin
    int       total;
    int       len;
    dma_req_t r;
    req_i = '0;
    req_valid_i = 1'b0;
    rd_req_ready_i = 1'b0;
    rd_data_i = '0;
    rd_valid_i = 1'b0;
    wr_req_ready_i = 1'b0;
    wr_ready_i = 1'b0;
    wr_resp_valid_i = 1'b0;
    seed = 32'h192d6c19;
    for (int a = 0; a < 2**`DMA_ADDR_W; a++) begin
      mem[a] = $random(seed);
    end
    ref_mem = mem;
    // sources in the lower half, destinations in the upper half
    total = 0;
    for (int i = 0; i < num_reqs; i++) begin
      r.src = addr_t'($unsigned($random(seed)) % 32'h7f00);
      r.dst = addr_t'(32'h8000 + $unsigned($random(seed)) % 32'h7f00);
      len = ($unsigned($random(seed)) % 8 == 0) ? 0 : 1 + $unsigned($random(seed)) % 200;
      r.num_words = len_t'(len);
      r.deburst = ($random(seed) & 3) == 0;
      r.serialize = ($random(seed) & 3) == 0;
      reqs[i] = r;
      gap[i] = $unsigned($random(seed)) % 3;
      total += len;
      if (len != 0) begin
        for (int j = 0; j < len; j++) begin
          ref_mem[r.dst + j] = ref_mem[r.src + j];
        end
        ser_of[n_nonzero] = r.serialize;
        expect_bursts(r.src, len, r.deburst, n_nonzero, 1'b1);
        expect_bursts(r.dst, len, r.deburst, n_nonzero, 1'b0);
        cum_wr[n_nonzero] = exp_wr.size();
        n_nonzero++;
      end
    end
    limit = total * 8 + 2000;

    @(posedge rst_ni);
    @(posedge clk_i);
    assert (idle_o && req_ready_o && !rd_req_valid_o && !wr_req_valid_o && !wr_valid_o &&
            !trans_complete_o) else begin
      $display("state after reset wrong, idle or ready low or a valid output high");
      err_reset++;
    end
    $display("test reset_state: %0d errors", err_reset);

    #1;
    for (int i = 0; i < num_reqs; i++) begin
      req_i = reqs[i];
      req_valid_i = 1'b1;
      do @(posedge clk_i); while (!req_ready_o);
      #1;
      req_valid_i = 1'b0;
      repeat (gap[i]) begin
        @(posedge clk_i);
        #1;
      end
    end

    // all nonzero requests retired and the backend drained
    while (cmpl_cnt != n_nonzero || !idle_o) @(negedge clk_i);

    for (int a = 0; a < 2**`DMA_ADDR_W; a++) begin
      assert (mem[a] == ref_mem[a]) else begin
        $display("Error at %0t: mem[%h] = %h, expected %h", $time, a[15:0], mem[a], ref_mem[a]);
        err_data++;
      end
    end
    $display("test data_integrity: %0d errors", err_data);
    assert (exp_rd.size() == 0 && exp_wr.size() == 0) else begin
      $display("%0d read and %0d write bursts never issued", exp_rd.size(), exp_wr.size());
      err_shape++;
    end
    $display("test burst_shape: %0d errors", err_shape);
    $display("test completion: %0d errors", err_cmpl);
    $display("test serialization: %0d errors", err_ser);
    assert (idle_o && rd_pend.size() == 0 && wr_pend.size() == 0 && resp_owed == 0) else begin
      $display("bus traffic still pending after all requests retired");
      err_idle++;
    end
    $display("test idle_after_retire: %0d errors", err_idle);

    total = err_reset + err_data + err_shape + err_cmpl + err_ser + err_idle +
            i_dma_backend.i_dma_backend_chk.fails;
    $display("%0d requests, %0d nonzero, %0d completions, %0d assertion failures, %0d errors",
             num_reqs, n_nonzero, cmpl_cnt, i_dma_backend.i_dma_backend_chk.fails, total);
    if (total == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
